//--- udp_defs.svh
`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// ethernet ii type for an ipv4 payload.
`define UDP_ETHERTYPE_IPV4 16'h0800

// ipv4 header, no options.
`define UDP_IP_VERSION 4'd4
`define UDP_IP_PROTO_UDP 8'h11

// udp header: ports, length and checksum.
`define UDP_HDR_BYTES 8

// payload buffer, depth is a power of two.
`define UDP_FIFO_DEPTH 128
`define UDP_FIFO_AW 7

`endif

//--- udp_pkg.sv
package udp_pkg;

    // one byte on the stream with its frame markers.
    typedef struct packed {
        logic [7:0] data;
        logic       sof;
        logic       eof;
    } stream_beat_t;

    // header fields in wire order.
    typedef enum logic [4:0] {
        eth_dst,
        eth_src,
        eth_type,
        ip_ver_ihl,
        ip_tos,
        ip_len,
        ip_id,
        ip_flags,
        ip_ttl,
        ip_proto,
        ip_csum,
        ip_src,
        ip_dst,
        udp_src,
        udp_dst,
        udp_len,
        udp_csum
    } field_e;

    typedef struct packed {
        logic        valid;
        logic [15:0] word;
    } csum_word_t;

    typedef struct packed {
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
        logic        field_done;  // last byte of the current field.
        logic        reject;
    } hdr_result_t;

    typedef enum logic [2:0] {
        st_wait_sof,
        st_header,
        st_payload,
        st_verdict,
        st_drain
    } parse_state_e;

endpackage

//--- payload_fifo.sv
`timescale 1ns/1ps
`include "udp_defs.svh"

module payload_fifo (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  wr_en,
    input  udp_pkg::stream_beat_t wr_beat,
    output logic                  full,
    input  logic                  rd_en,
    output udp_pkg::stream_beat_t rd_beat,
    output logic                  empty
);

    udp_pkg::stream_beat_t   mem [`UDP_FIFO_DEPTH];
    logic [`UDP_FIFO_AW-1:0] wr_ptr;
    logic [`UDP_FIFO_AW-1:0] rd_ptr;
    logic [`UDP_FIFO_AW:0]   count;
    logic                    first_pending;
    logic                    do_wr;
    logic                    do_rd;
    udp_pkg::stream_beat_t   wr_entry;

    assign full    = count[`UDP_FIFO_AW];  // count equals depth.
    assign empty   = count == '0;
    assign do_wr   = wr_en && !full;
    assign do_rd   = rd_en && !empty;
    assign rd_beat = mem[rd_ptr];

    // first beat since the last clear carries sof.
    always_comb begin
        wr_entry     = wr_beat;
        wr_entry.sof = wr_beat.sof || first_pending;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            first_pending <= 1'b1;
        end else if (clear) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            first_pending <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr        <= wr_ptr + 1'b1;
                first_pending <= 1'b0;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr && !clear) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

endmodule

//--- checksum_accum.sv
`timescale 1ns/1ps

module checksum_accum (
    input  logic                 clock,
    input  logic                 reset,
    input  udp_pkg::csum_word_t  csum_word,
    input  logic                 pay_take,
    input  logic [7:0]           pay_byte,
    input  logic                 pay_last,
    input  logic                 finish,
    input  udp_pkg::hdr_result_t hdr,
    output logic                 csum_ready,
    output logic                 csum_match
);

    logic [31:0] sum;
    logic [7:0]  hi_byte;
    logic        hi_pending;
    logic [15:0] pay_word;
    logic        pay_word_valid;
    logic [31:0] hdr_add;
    logic [31:0] pay_add;
    logic        restart;

    // verdict taken or header rejected, so the next frame starts from zero.
    assign restart = (finish && csum_ready) || hdr.reject;

    always_comb begin
        pay_word       = {hi_byte, pay_byte};
        pay_word_valid = 1'b0;
        if (pay_take) begin
            if (hi_pending) begin
                pay_word_valid = 1'b1;
            end else if (pay_last) begin
                pay_word       = {pay_byte, 8'h00};  // odd length, zero low byte.
                pay_word_valid = 1'b1;
            end
        end
    end

    assign hdr_add = csum_word.valid ? {16'h0000, csum_word.word} : 32'h0;
    assign pay_add = pay_word_valid ? {16'h0000, pay_word} : 32'h0;

    assign csum_ready = finish && (sum[31:16] == 16'h0000);
    assign csum_match = csum_ready && (~sum[15:0] == hdr.udp_checksum);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sum        <= '0;
            hi_pending <= 1'b0;
        end else if (restart) begin
            sum        <= '0;
            hi_pending <= 1'b0;
        end else if (finish) begin
            sum <= {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};  // end-around carry.
        end else begin
            sum <= sum + hdr_add + pay_add;
            if (pay_take) begin
                hi_pending <= !hi_pending && !pay_last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pay_take && !hi_pending) begin
            hi_byte <= pay_byte;
        end
    end

endmodule

//--- header_capture.sv
`timescale 1ns/1ps
`include "udp_defs.svh"

module header_capture (
    input  logic                 clock,
    input  logic                 reset,
    input  udp_pkg::field_e      field,
    input  logic                 byte_take,
    input  logic [7:0]           byte_in,
    output udp_pkg::hdr_result_t hdr,
    output udp_pkg::csum_word_t  csum_word
);

    logic [2:0]          byte_cnt;
    logic [15:0]         value;
    logic [15:0]         assembled;
    logic [15:0]         udp_length;
    logic [15:0]         udp_checksum;
    logic                last;
    logic                bad;
    udp_pkg::csum_word_t word_next;

    function automatic logic [2:0] field_bytes(input udp_pkg::field_e f);
        case (f)
            udp_pkg::eth_dst, udp_pkg::eth_src: field_bytes = 3'd6;
            udp_pkg::ip_src, udp_pkg::ip_dst: field_bytes = 3'd4;
            udp_pkg::ip_ver_ihl, udp_pkg::ip_tos: field_bytes = 3'd1;
            udp_pkg::ip_ttl, udp_pkg::ip_proto: field_bytes = 3'd1;
            default: field_bytes = 3'd2;
        endcase
    endfunction

    assign assembled = {value[7:0], byte_in};  // big endian with the newest byte lowest.
    assign last = byte_take && (byte_cnt == field_bytes(field) - 3'd1);

    always_comb begin
        case (field)
            udp_pkg::eth_type: bad = assembled[15:0] != `UDP_ETHERTYPE_IPV4;
            udp_pkg::ip_ver_ihl: bad = byte_in[7:4] != `UDP_IP_VERSION;
            udp_pkg::ip_ttl: bad = byte_in == 8'h00;
            udp_pkg::ip_proto: bad = byte_in != `UDP_IP_PROTO_UDP;
            // payload must be non-empty and fit the buffer.
            udp_pkg::udp_len: bad = (assembled[15:0] <= 16'(`UDP_HDR_BYTES)) ||
                (assembled[15:0] > 16'(`UDP_HDR_BYTES + `UDP_FIFO_DEPTH));
            default: bad = 1'b0;
        endcase
    end

    always_comb begin
        hdr.udp_length   = udp_length;
        hdr.udp_checksum = udp_checksum;
        hdr.field_done   = last;
        hdr.reject       = last && bad;
    end

    // pseudo-header and udp header words without the checksum field.
    always_comb begin
        word_next = '0;
        if (byte_take) begin
            case (field)
                udp_pkg::ip_src, udp_pkg::ip_dst: begin
                    word_next.valid = byte_cnt[0];
                    word_next.word  = assembled[15:0];
                end
                udp_pkg::udp_src, udp_pkg::udp_dst, udp_pkg::udp_len: begin
                    word_next.valid = last && !bad;
                    word_next.word  = assembled[15:0];
                end
                udp_pkg::ip_proto: begin
                    word_next.valid = last && !bad;
                    word_next.word  = {8'h00, byte_in};
                end
                udp_pkg::udp_csum: begin
                    word_next.valid = byte_cnt == 3'd0;  // length again for the pseudo-header.
                    word_next.word  = udp_length;
                end
                default: word_next = '0;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            byte_cnt  <= '0;
            csum_word <= '0;
        end else begin
            csum_word <= word_next;
            if (byte_take) begin
                byte_cnt <= last ? 3'd0 : byte_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (byte_take) begin
            value <= assembled;
        end
        if (last && field == udp_pkg::udp_len) begin
            udp_length <= assembled[15:0];
        end
        if (last && field == udp_pkg::udp_csum) begin
            udp_checksum <= assembled[15:0];
        end
    end

endmodule

//--- parse_control.sv
`timescale 1ns/1ps
`include "udp_defs.svh"

module parse_control (
    input  logic                  clock,
    input  logic                  reset,
    input  udp_pkg::stream_beat_t in_beat,
    input  logic                  in_empty,
    output logic                  in_rd_en,
    output udp_pkg::field_e       field,
    output logic                  byte_take,
    input  udp_pkg::hdr_result_t  hdr,
    output logic                  pay_take,
    output logic                  pay_last,
    output logic                  finish,
    input  logic                  csum_ready,
    input  logic                  csum_match,
    output logic                  fifo_wr_en,
    input  logic                  fifo_full,
    input  logic                  fifo_empty,
    input  logic                  fifo_head_eof,
    output logic                  fifo_rd_en,
    output logic                  fifo_clear,
    input  logic                  out_full,
    output logic                  out_wr_en
);

    udp_pkg::parse_state_e state;
    udp_pkg::parse_state_e state_next;
    udp_pkg::field_e       field_next;
    logic [15:0]           remaining;
    logic [15:0]           remaining_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= udp_pkg::st_wait_sof;
            field     <= udp_pkg::eth_dst;
            remaining <= '0;
        end else begin
            state     <= state_next;
            field     <= field_next;
            remaining <= remaining_next;
        end
    end

    always_comb begin
        state_next     = state;
        field_next     = field;
        remaining_next = remaining;
        in_rd_en       = 1'b0;
        byte_take      = 1'b0;
        pay_take       = 1'b0;
        pay_last       = 1'b0;
        finish         = 1'b0;
        fifo_wr_en     = 1'b0;
        fifo_rd_en     = 1'b0;
        fifo_clear     = 1'b0;
        out_wr_en      = 1'b0;
        case (state)
            udp_pkg::st_wait_sof: begin
                if (!in_empty) begin
                    if (in_beat.sof) begin
                        state_next = udp_pkg::st_header;  // sof byte is the first header byte.
                        field_next = udp_pkg::eth_dst;
                    end else begin
                        in_rd_en = 1'b1;  // discard.
                    end
                end
            end
            udp_pkg::st_header: begin
                byte_take = !in_empty;
                in_rd_en  = !in_empty;
                if (hdr.field_done) begin
                    if (hdr.reject) begin
                        fifo_clear = 1'b1;
                        state_next = udp_pkg::st_wait_sof;
                    end else if (field == udp_pkg::udp_csum) begin
                        remaining_next = hdr.udp_length - 16'(`UDP_HDR_BYTES);
                        state_next     = udp_pkg::st_payload;
                    end else begin
                        field_next = udp_pkg::field_e'(field + 5'd1);
                    end
                end
            end
            udp_pkg::st_payload: begin
                pay_take   = !in_empty && !fifo_full;
                pay_last   = pay_take && (remaining == 16'd1);
                in_rd_en   = pay_take;
                fifo_wr_en = pay_take;
                if (pay_take) begin
                    remaining_next = remaining - 16'd1;
                    if (pay_last) begin
                        state_next = udp_pkg::st_verdict;
                    end
                end
            end
            udp_pkg::st_verdict: begin
                finish = 1'b1;  // held until the sum is folded.
                if (csum_ready) begin
                    if (csum_match) begin
                        state_next = udp_pkg::st_drain;
                    end else begin
                        fifo_clear = 1'b1;
                        state_next = udp_pkg::st_wait_sof;
                    end
                end
            end
            udp_pkg::st_drain: begin
                out_wr_en  = !fifo_empty && !out_full;
                fifo_rd_en = out_wr_en;
                if (out_wr_en && fifo_head_eof) begin
                    fifo_clear = 1'b1;
                    state_next = udp_pkg::st_wait_sof;
                end
            end
            default: state_next = udp_pkg::st_wait_sof;
        endcase
    end

endmodule

//--- udp_parser_top.sv
`timescale 1ns/1ps

module udp_parser_top (
    input  logic                  clock,
    input  logic                  reset,
    input  udp_pkg::stream_beat_t in_beat,
    input  logic                  in_empty,
    output logic                  in_rd_en,
    output udp_pkg::stream_beat_t out_beat,
    output logic                  out_wr_en,
    output logic                  out_empty,
    input  logic                  out_full
);

    udp_pkg::field_e       field;
    udp_pkg::hdr_result_t  hdr;
    udp_pkg::csum_word_t   csum_word;
    udp_pkg::stream_beat_t fifo_wr_beat;
    logic                  byte_take;
    logic                  pay_take;
    logic                  pay_last;
    logic                  finish;
    logic                  csum_ready;
    logic                  csum_match;
    logic                  fifo_wr_en;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  fifo_rd_en;
    logic                  fifo_clear;

    assign fifo_wr_beat = '{data: in_beat.data, sof: 1'b0, eof: pay_last};
    assign out_empty    = fifo_empty;

    parse_control parse_control_inst (
        .clock(clock),
        .reset(reset),
        .in_beat(in_beat),
        .in_empty(in_empty),
        .in_rd_en(in_rd_en),
        .field(field),
        .byte_take(byte_take),
        .hdr(hdr),
        .pay_take(pay_take),
        .pay_last(pay_last),
        .finish(finish),
        .csum_ready(csum_ready),
        .csum_match(csum_match),
        .fifo_wr_en(fifo_wr_en),
        .fifo_full(fifo_full),
        .fifo_empty(fifo_empty),
        .fifo_head_eof(out_beat.eof),
        .fifo_rd_en(fifo_rd_en),
        .fifo_clear(fifo_clear),
        .out_full(out_full),
        .out_wr_en(out_wr_en)
    );

    header_capture header_capture_inst (
        .clock(clock),
        .reset(reset),
        .field(field),
        .byte_take(byte_take),
        .byte_in(in_beat.data),
        .hdr(hdr),
        .csum_word(csum_word)
    );

    checksum_accum checksum_accum_inst (
        .clock(clock),
        .reset(reset),
        .csum_word(csum_word),
        .pay_take(pay_take),
        .pay_byte(in_beat.data),
        .pay_last(pay_last),
        .finish(finish),
        .hdr(hdr),
        .csum_ready(csum_ready),
        .csum_match(csum_match)
    );

    payload_fifo payload_fifo_inst (
        .clock(clock),
        .reset(reset),
        .clear(fifo_clear),
        .wr_en(fifo_wr_en),
        .wr_beat(fifo_wr_beat),
        .full(fifo_full),
        .rd_en(fifo_rd_en),
        .rd_beat(out_beat),
        .empty(fifo_empty)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // release on a falling edge, away from the active clock edge.
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

//--- udp_parser_tb.sv
`timescale 1ns/1ps

module udp_parser_tb;

    localparam int kind_valid       = 0;
    localparam int kind_bad_type    = 1;
    localparam int kind_bad_version = 2;
    localparam int kind_ttl_zero    = 3;
    localparam int kind_bad_proto   = 4;
    localparam int kind_bad_csum    = 5;
    localparam int kind_bad_payload = 6;
    localparam int directed_frames  = 13;
    localparam int random_frames    = 60;

    logic                  clock;
    logic                  reset;
    udp_pkg::stream_beat_t in_beat;
    logic                  in_empty;
    logic                  in_rd_en;
    udp_pkg::stream_beat_t out_beat;
    logic                  out_wr_en;
    logic                  out_empty;
    logic                  out_full;

    udp_pkg::stream_beat_t in_q[$];   // upstream fifo contents.
    udp_pkg::stream_beat_t exp_q[$];  // beats the DUT must still emit.
    logic [7:0]            frame_bytes[$];
    logic [31:0]           rng_state = 32'd88833;
    logic                  throttle = 1'b0;
    logic                  in_took;
    int                    directed_kind[directed_frames] = '{
        kind_valid, kind_valid, kind_bad_type, kind_valid, kind_bad_version, kind_valid,
        kind_ttl_zero, kind_valid, kind_bad_proto, kind_valid, kind_bad_csum,
        kind_bad_payload, kind_valid
    };

    tb_clock_gen #(.period_ns(40), .reset_cycles(10)) tb_clock_gen_inst (
        .clock(clock),
        .reset(reset)
    );

    udp_parser_top udp_parser_top_inst (
        .clock(clock),
        .reset(reset),
        .in_beat(in_beat),
        .in_empty(in_empty),
        .in_rd_en(in_rd_en),
        .out_beat(out_beat),
        .out_wr_en(out_wr_en),
        .out_empty(out_empty),
        .out_full(out_full)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] add_word(input logic [31:0] sum, input logic [15:0] w);
        return sum + {16'h0000, w};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, expected));
        end
    endtask

    task automatic push_word(input logic [15:0] w);
        frame_bytes.push_back(w[15:8]);  // network order.
        frame_bytes.push_back(w[7:0]);
    endtask

    // builds one ethernet/ipv4/udp frame and queues its payload as expected output when it passes.
    task automatic build_frame(input int kind, input int len);
        logic [7:0]            pay[$];
        logic [7:0]            lo;
        logic [31:0]           sum;
        logic [31:0]           src_ip;
        logic [31:0]           dst_ip;
        logic [15:0]           sport;
        logic [15:0]           dport;
        logic [15:0]           udp_len;
        logic [15:0]           csum;
        int                    idx;
        udp_pkg::stream_beat_t beat;
        frame_bytes.delete();
        udp_len = 16'(len + 8);
        src_ip  = next_rand();
        dst_ip  = next_rand();
        sport   = 16'(next_rand());
        dport   = 16'(next_rand());
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'(next_rand()));
        end
        // pseudo-header then udp header without its checksum.
        sum = 32'h0;
        sum = add_word(sum, src_ip[31:16]);
        sum = add_word(sum, src_ip[15:0]);
        sum = add_word(sum, dst_ip[31:16]);
        sum = add_word(sum, dst_ip[15:0]);
        sum = add_word(sum, 16'h0011);
        sum = add_word(sum, udp_len);
        sum = add_word(sum, sport);
        sum = add_word(sum, dport);
        sum = add_word(sum, udp_len);
        for (int i = 0; i < len; i += 2) begin
            lo = 8'h00;  // odd tail.
            if (i + 1 < len) begin
                lo = pay[i + 1];
            end
            sum = add_word(sum, {pay[i], lo});
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[31:16]} + {16'h0000, sum[15:0]};
        end
        csum = ~sum[15:0];
        if (kind == kind_bad_csum) begin
            csum = csum ^ (16'h0001 << (next_rand() % 16));
        end
        if (kind == kind_bad_payload) begin
            idx      = int'(next_rand() % 32'(len));
            pay[idx] = pay[idx] ^ 8'hff;
        end
        for (int i = 0; i < 12; i++) begin
            frame_bytes.push_back(8'(next_rand()));  // mac addresses.
        end
        push_word((kind == kind_bad_type) ? 16'h86dd : 16'h0800);
        frame_bytes.push_back((kind == kind_bad_version) ? 8'h65 : 8'h45);
        frame_bytes.push_back(8'h00);
        push_word(16'(len + 28));
        push_word(16'(next_rand()));
        push_word(16'h4000);
        frame_bytes.push_back((kind == kind_ttl_zero) ? 8'h00 : 8'(1 + next_rand() % 255));
        frame_bytes.push_back((kind == kind_bad_proto) ? 8'h06 : 8'h11);
        push_word(16'(next_rand()));
        push_word(src_ip[31:16]);
        push_word(src_ip[15:0]);
        push_word(dst_ip[31:16]);
        push_word(dst_ip[15:0]);
        push_word(sport);
        push_word(dport);
        push_word(udp_len);
        push_word(csum);
        for (int i = 0; i < len; i++) begin
            frame_bytes.push_back(pay[i]);
        end
        for (int i = 0; i < frame_bytes.size(); i++) begin
            beat.data = frame_bytes[i];
            beat.sof  = (i == 0);
            beat.eof  = (i == frame_bytes.size() - 1);
            in_q.push_back(beat);
        end
        if (kind == kind_valid) begin
            for (int i = 0; i < len; i++) begin
                beat.data = pay[i];
                beat.sof  = (i == 0);
                beat.eof  = (i == len - 1);
                exp_q.push_back(beat);
            end
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            #3;
            cycles++;
            if (cycles > 100) begin
                abort_run("reset was never released");
            end
        end while (reset);
    endtask

    task automatic wait_frame_done();
        int cycles;
        cycles = 0;
        while (in_q.size() != 0 || !out_empty) begin
            @(negedge clock);
            #3;
            cycles++;
            if (cycles > 4000) begin
                abort_run("timeout while the DUT consumed and drained a frame");
            end
        end
    endtask

    // upstream fifo and downstream sink driven on the falling edge.
    initial begin
        udp_pkg::stream_beat_t expected;
        logic [31:0]           r;
        in_beat  = '0;
        in_empty = 1'b1;
        out_full = 1'b0;
        in_took  = 1'b0;
        forever begin
            @(negedge clock);
            if (in_took) begin
                void'(in_q.pop_front());
            end
            r        = next_rand();
            in_empty = (in_q.size() == 0) || (throttle && r[0]);
            if (in_q.size() != 0) begin
                in_beat = in_q[0];
            end
            out_full = throttle && r[1];
            #1;
            in_took = !reset && in_rd_en && !in_empty;  // transfer on the coming edge.
            if (!reset) begin
                check_value("out_wr_en while out_full", 32'(out_wr_en && out_full), 32'd0);
                if (out_wr_en) begin
                    if (exp_q.size() == 0) begin
                        abort_run("output beat from a frame that should have been dropped");
                    end else begin
                        expected = exp_q.pop_front();
                        check_value("out_beat.data", 32'(out_beat.data), 32'(expected.data));
                        check_value("out_beat.sof", 32'(out_beat.sof), 32'(expected.sof));
                        check_value("out_beat.eof", 32'(out_beat.eof), 32'(expected.eof));
                    end
                end
            end
        end
    end

    initial begin
        int          kind;
        int          len;
        logic [31:0] r;
        wait_reset_release();
        check_value("in_rd_en", 32'(in_rd_en), 32'd0);
        check_value("out_wr_en", 32'(out_wr_en), 32'd0);
        check_value("out_empty", 32'(out_empty), 32'd1);
        for (int i = 0; i < directed_frames + random_frames; i++) begin
            r = next_rand();
            if (i < directed_frames) begin
                kind     = directed_kind[i];
                throttle = 1'b0;
            end else begin
                kind     = (r[2:0] == 3'd7) ? kind_valid : int'(r[2:0]);
                throttle = r[3];  // random stalls on both sides.
            end
            len = (i == 0) ? 12 : ((i == 1) ? 13 : 1 + int'(r[15:8] % 8'd40));
            build_frame(kind, len);
            wait_frame_done();
        end
        check_value("expected beats left", 32'(exp_q.size()), 32'd0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
udp_pkg.sv
payload_fifo.sv
checksum_accum.sv
header_capture.sv
parse_control.sv
udp_parser_top.sv
tb_clock_gen.sv
udp_parser_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = udp_parser_tb
RTL_TOP   = udp_parser_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
